//--- all.f
+incdir+hw
hw/mdu_pkg.sv
hw/mdu_div_ctl_if.sv
hw/mdu_yreg.sv
hw/mdu_seq.sv
hw/mdu_div_dp.sv
hw/mdu_mul.sv
hw/mdu_top.sv
verif/mdu_checker.sv
verif/tb_mdu.sv

//--- verif/tb_mdu.sv
`timescale 1ns/1ns
`include "mdu_consts.svh"

module tb_mdu
   import mdu_pkg::*;
;

   logic      rclk;
   logic      arst_n;
   logic      start;
   mdu_op_e   op;
   mdu_thr_t  thr;
   mdu_word_t rs1;
   mdu_word_t rs2;
   logic      y_wen;
   mdu_thr_t  y_wthr;
   mdu_word_t y_wdata;
   mdu_thr_t  y_rthr;
   logic      busy;
   logic      done;
   mdu_word_t result;
   logic      flag_n;
   logic      flag_z;
   logic      flag_v;
   logic      div_zero;
   mdu_word_t y_rdata;

   mdu_word_t exp_res;
   logic      exp_n;
   logic      exp_z;
   logic      exp_v;
   logic      exp_dz;
   logic      y_chk;
   mdu_word_t y_exp;
   int        val_errs;
   int        seq_errs;
   int        tmo_errs;
   mdu_word_t y_model [`MDU_NUM_THR];   // Software view of the Y registers
   mdu_word_t corners [4] = '{32'h0, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
   mdu_word_t a;
   mdu_word_t b;
   mdu_thr_t  t;
   event      stalled;                  // Raised by a wait that timed out

   always #2 rclk = ~rclk;   // 4 ns period

   mdu_top u_dut (
      .rclk(rclk), .arst_n(arst_n), .start(start), .op(op), .thr(thr),
      .rs1(rs1), .rs2(rs2), .y_wen(y_wen), .y_wthr(y_wthr), .y_wdata(y_wdata),
      .y_rthr(y_rthr), .busy(busy), .done(done), .result(result),
      .flag_n(flag_n), .flag_z(flag_z), .flag_v(flag_v), .div_zero(div_zero),
      .y_rdata(y_rdata)
   );

   mdu_checker u_chk (
      .rclk(rclk), .arst_n(arst_n), .start(start), .op(op), .busy(busy),
      .done(done), .result(result), .flag_n(flag_n), .flag_z(flag_z),
      .flag_v(flag_v), .div_zero(div_zero), .y_rdata(y_rdata),
      .exp_res(exp_res), .exp_n(exp_n), .exp_z(exp_z), .exp_v(exp_v),
      .exp_dz(exp_dz), .y_chk(y_chk), .y_exp(y_exp),
      .val_errs(val_errs), .seq_errs(seq_errs)
   );

   ////////////////////////////////////////
   // Reference outcome packed as {div_zero, v, z, n, new_y, result}
   ////////////////////////////////////////
   function automatic logic [67:0] ref_model(mdu_op_e f_op, mdu_word_t y, mdu_word_t x,
                                              mdu_word_t d);
      mdu_dword_t full;
      mdu_dword_t mag;
      mdu_word_t  dvs;
      mdu_word_t  res;
      mdu_word_t  y_new;
      logic       neg;
      logic       ovf;
      logic       dz;
      neg   = 1'b0;
      ovf   = 1'b0;
      dz    = 1'b0;
      res   = '0;
      y_new = y;
      if (f_op == UMUL || f_op == SMUL) begin
         if (f_op == SMUL) begin
            full = {{32{x[31]}}, x} * {{32{d[31]}}, d};   // Low 64 bits of signed product
         end else begin
            full = {32'h0, x} * {32'h0, d};
         end
         res   = full[31:0];
         y_new = full[63:32];
      end else if (d == 32'h0) begin
         dz = 1'b1;
      end else begin
         full = {y, x};
         mag  = full;
         dvs  = d;
         if (f_op == SDIV) begin
            neg = full[63] ^ d[31];
            mag = full[63] ? -full : full;
            dvs = d[31] ? -d : d;
         end
         mag = mag / {32'h0, dvs};   // Quotient magnitude
         if (f_op == UDIV) begin
            ovf = mag > 64'hFFFF_FFFF;
         end else begin
            ovf = neg ? (mag > 64'h8000_0000) : (mag > 64'h7FFF_FFFF);
         end
         if (ovf) begin
            res = (f_op == UDIV) ? 32'hFFFF_FFFF : (neg ? 32'h8000_0000 : 32'h7FFF_FFFF);
         end else begin
            res = neg ? -mag[31:0] : mag[31:0];
         end
      end
      return {dz, ovf, res == 32'h0, res[31], y_new, res};
   endfunction

   task automatic end_run();
      $display("errors: value %0d, sequence %0d, timeout %0d", val_errs, seq_errs, tmo_errs);
      if (val_errs + seq_errs + tmo_errs == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   endtask

   // Timed-out stimulus stops here for good
   task automatic halt_on_timeout(string what);
      $display("Timeout: %s at %0t", what, $time);
      tmo_errs++;
      -> stalled;
      forever @(negedge rclk);
   endtask

   // Run end after a timeout
   initial begin
      @(stalled);
      end_run();
   end

   ////////////////////////////////////////
   // Stimulus tasks entered and left on a falling edge
   ////////////////////////////////////////
   task automatic wait_idle();
      int n;
      n = 0;
      while (busy && n < 10) begin
         @(negedge rclk);
         n++;
      end
      if (busy) begin
         halt_on_timeout("busy stayed high for 10 cycles");
      end
   endtask

   task automatic sw_write(mdu_thr_t wt, mdu_word_t wd);
      y_wen   = 1'b1;
      y_wthr  = wt;
      y_wdata = wd;
      @(negedge rclk);
      y_wen      = 1'b0;
      y_model[wt] = wd;
   endtask

   task automatic y_read_check(mdu_thr_t rt);
      y_rthr = rt;
      y_exp  = y_model[rt];
      y_chk  = 1'b1;
      @(negedge rclk);
      y_chk = 1'b0;
   endtask

   // Clash writes Y in software on the multiply's write edge, poke starts while busy
   task automatic issue(mdu_op_e i_op, mdu_thr_t i_thr, mdu_word_t x, mdu_word_t d,
                        logic clash, logic poke);
      logic [67:0] ev;
      int          n;
      wait_idle();
      ev = ref_model(i_op, y_model[i_thr], x, d);
      {exp_dz, exp_v, exp_z, exp_n} = ev[67:64];
      exp_res = ev[31:0];
      op    = i_op;
      thr   = i_thr;
      rs1   = x;
      rs2   = d;
      start = 1'b1;
      @(negedge rclk);
      start = 1'b0;
      if (clash) begin
         repeat (2) @(negedge rclk);   // Cycle before the result edge
         y_wen   = 1'b1;
         y_wthr  = i_thr;
         y_wdata = ~ev[63:32];
         @(negedge rclk);
         y_wen = 1'b0;
      end
      n = 0;
      while (!done && n < 100) begin
         start = poke && (n == 4);
         op    = start ? UMUL : i_op;
         @(negedge rclk);
         n++;
      end
      start = 1'b0;
      if (!done) begin
         halt_on_timeout("done did not arrive within 100 cycles");
      end
      if (!i_op[1]) begin
         y_model[i_thr] = clash ? ~ev[63:32] : ev[63:32];   // Software write wins
      end
   endtask

   initial begin
      void'($urandom(38));
      rclk     = 1'b0;
      arst_n   = 1'b0;
      start    = 1'b0;
      op       = UMUL;
      thr      = '0;
      rs1      = '0;
      rs2      = '0;
      y_wen    = 1'b0;
      y_wthr   = '0;
      y_wdata  = '0;
      y_rthr   = '0;
      y_chk    = 1'b0;
      y_exp    = '0;
      exp_res  = '0;
      {exp_n, exp_z, exp_v, exp_dz} = '0;
      tmo_errs = 0;
      for (int i = 0; i < `MDU_NUM_THR; i++) begin
         y_model[i] = '0;
      end
      repeat (2) @(negedge rclk);
      arst_n = 1'b1;
      @(negedge rclk);

      // Per-thread Y write and readback
      for (int i = 0; i < `MDU_NUM_THR; i++) begin
         sw_write(mdu_thr_t'(i), 32'h0101_0101 * (i + 1));
      end
      for (int i = 0; i < `MDU_NUM_THR; i++) begin
         y_read_check(mdu_thr_t'(i));
      end
      issue(UDIV, 2'd2, 32'h1234_5678, 32'hFFFF_FFF1, 1'b0, 1'b0);   // Own thread's Y only
      issue(SDIV, 2'd1, 32'h89AB_CDEF, 32'h7FFF_0003, 1'b0, 1'b0);

      // Multiply corners
      for (int i = 0; i < 4; i++) begin
         for (int j = 0; j < 4; j++) begin
            issue(UMUL, mdu_thr_t'(i), corners[i], corners[j], 1'b0, 1'b0);
            y_read_check(mdu_thr_t'(i));
            issue(SMUL, mdu_thr_t'(j), corners[i], corners[j], 1'b0, 1'b0);
            y_read_check(mdu_thr_t'(j));
         end
      end

      // Random multiplies
      repeat (16) begin
         t = mdu_thr_t'($urandom);
         issue($urandom % 2 ? SMUL : UMUL, t, $urandom, $urandom, 1'b0, 1'b0);
         y_read_check(t);
      end

      // Divides that fit
      repeat (12) begin
         t = mdu_thr_t'($urandom);
         b = $urandom | 32'h1;
         sw_write(t, $urandom % b);   // Y below divisor keeps the quotient in 32 bits
         issue(UDIV, t, $urandom, b, 1'b0, 1'b0);
         a = $urandom;
         b = $urandom;
         if (b == 32'h0) begin
            b = 32'h7;
         end
         sw_write(t, {32{a[31]}});
         issue(SDIV, t, a, b, 1'b0, 1'b0);
      end

      // Overflow and the negative boundary
      sw_write(2'd0, 32'h5);
      issue(UDIV, 2'd0, 32'h0, 32'h3, 1'b0, 1'b0);
      sw_write(2'd1, 32'h0);
      issue(SDIV, 2'd1, 32'h8000_0000, 32'h1, 1'b0, 1'b0);
      sw_write(2'd2, 32'hFFFF_FFFF);
      issue(SDIV, 2'd2, 32'h0, 32'h1, 1'b0, 1'b0);
      issue(SDIV, 2'd2, 32'h8000_0000, 32'h1, 1'b0, 1'b0);   // Exactly -2^31 still fits
      issue(SDIV, 2'd2, 32'h0, 32'hFFFF_FFFF, 1'b0, 1'b0);

      // Divide by zero
      issue(UDIV, 2'd3, 32'hDEAD_BEEF, 32'h0, 1'b0, 1'b0);
      issue(SDIV, 2'd2, 32'h1, 32'h0, 1'b0, 1'b0);

      // Software write against the multiply's Y write
      issue(SMUL, 2'd1, 32'hFFFF_FFF0, 32'h0000_1234, 1'b1, 1'b0);
      y_read_check(2'd1);
      issue(UMUL, 2'd3, 32'hCAFE_0001, 32'h0000_0100, 1'b1, 1'b0);
      y_read_check(2'd3);

      // Start while busy must be dropped
      sw_write(2'd3, 32'h0000_0007);
      issue(UDIV, 2'd3, 32'h1357_9BDF, 32'h0001_0000, 1'b0, 1'b1);
      repeat (10) @(negedge rclk);   // Room for a stray done
      end_run();
   end

endmodule

//--- verif/mdu_checker.sv
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_checker
   import mdu_pkg::*;
(
   input  logic      rclk,
   input  logic      arst_n,
   input  logic      start,
   input  mdu_op_e   op,
   input  logic      busy,
   input  logic      done,
   input  mdu_word_t result,
   input  logic      flag_n,
   input  logic      flag_z,
   input  logic      flag_v,
   input  logic      div_zero,
   input  mdu_word_t y_rdata,
   input  mdu_word_t exp_res,    // Expected outcome valid with start
   input  logic      exp_n,
   input  logic      exp_z,
   input  logic      exp_v,
   input  logic      exp_dz,
   input  logic      y_chk,      // Compare y_rdata in this cycle
   input  mdu_word_t y_exp,
   output int        val_errs,
   output int        seq_errs
);

   int        n_val = 0;
   int        n_seq = 0;
   int        cyc = 0;          // Edges since reset release
   int        start_cyc;
   int        lat;
   int        lat_exp;
   logic      pending = 1'b0;   // Operation accepted and done not yet seen
   logic      holding = 1'b0;   // At least one outcome delivered
   mdu_word_t res_q;
   logic      n_q;
   logic      z_q;
   logic      v_q;
   logic      dz_q;
   mdu_word_t res_h;            // Outcome of the last done
   logic      n_h;
   logic      z_h;
   logic      v_h;
   logic      dz_h;

   assign val_errs = n_val;
   assign seq_errs = n_seq;

   task automatic compare(string name, logic [31:0] exp_val, logic [31:0] got);
      if (exp_val !== got) begin
         $display("Fail %0t %s expected %0h got %0h", $time, name, exp_val, got);
         n_val++;
      end
   endtask

   ////////////////////////////////////////
   // Sampled on the rising edge with inputs and outputs settled
   ////////////////////////////////////////
   always @(posedge rclk) begin
      if (arst_n) begin
         cyc++;
         if (y_chk) begin
            compare("y_rdata", y_exp, y_rdata);
         end
         if (pending && !busy) begin
            $display("busy went low at %0t before the operation finished", $time);
            n_seq++;
         end
         if (done && !pending) begin
            $display("done pulsed at %0t with no operation issued", $time);
            n_seq++;
         end else if (done) begin
            lat = cyc - start_cyc - 1;   // done seen one edge after it rose
            if (lat != lat_exp) begin
               $display("Fail %0t done latency expected %0d got %0d", $time, lat_exp, lat);
               n_seq++;
            end
            compare("result", res_q, result);
            compare("flag_n", n_q, flag_n);
            compare("flag_z", z_q, flag_z);
            compare("flag_v", v_q, flag_v);
            compare("div_zero", dz_q, div_zero);
            pending = 1'b0;
            holding = 1'b1;
            res_h   = res_q;
            n_h     = n_q;
            z_h     = z_q;
            v_h     = v_q;
            dz_h    = dz_q;
         end else if (holding) begin
            // Outputs keep the last outcome until the next done
            compare("result", res_h, result);
            compare("flag_n", n_h, flag_n);
            compare("flag_z", z_h, flag_z);
            compare("flag_v", v_h, flag_v);
            compare("div_zero", dz_h, div_zero);
         end
         // Latch the expected outcome of an accepted issue
         if (start && !busy) begin
            res_q     = exp_res;
            n_q       = exp_n;
            z_q       = exp_z;
            v_q       = exp_v;
            dz_q      = exp_dz;
            start_cyc = cyc;
            pending   = 1'b1;
            if (!op[1]) begin
               lat_exp = `MDU_MUL_LAT + 1;
            end else begin
               lat_exp = exp_dz ? 2 : `MDU_DIV_ITERS + 3;   // Load, steps, fix, register
            end
         end
      end
   end

endmodule

//--- hw/mdu_top.sv
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_top
   import mdu_pkg::*;
(
   input  logic      rclk,
   input  logic      arst_n,
   input  logic      start,
   input  mdu_op_e   op,
   input  mdu_thr_t  thr,
   input  mdu_word_t rs1,
   input  mdu_word_t rs2,
   input  logic      y_wen,     // Software Y write
   input  mdu_thr_t  y_wthr,
   input  mdu_word_t y_wdata,
   input  mdu_thr_t  y_rthr,    // Software Y read
   output logic      busy,
   output logic      done,
   output mdu_word_t result,
   output logic      flag_n,
   output logic      flag_z,
   output logic      flag_v,
   output logic      div_zero,
   output mdu_word_t y_rdata
);

   mdu_div_ctl_if div_ctl ();

   logic       mul_start;
   logic       mul_signed;
   logic       mul_valid;
   logic       y_mul_wen;
   mdu_dword_t product;
   mdu_thr_t   op_thr;      // Thread of the op in flight
   mdu_word_t  y_op;

   mdu_seq u_seq (
      .rclk(rclk), .arst_n(arst_n),
      .start(start), .op(op), .thr(thr), .mul_valid(mul_valid),
      .busy(busy), .done(done), .div_zero(div_zero),
      .mul_start(mul_start), .mul_signed(mul_signed),
      .y_mul_wen(y_mul_wen), .op_thr(op_thr), .ctl(div_ctl.ctl)
   );

   mdu_div_dp u_div_dp (
      .rclk(rclk), .arst_n(arst_n),
      .rs1(rs1), .rs2(rs2), .y_op(y_op), .product(product), .done(done),
      .result(result), .flag_n(flag_n), .flag_z(flag_z), .flag_v(flag_v),
      .ctl(div_ctl.dp)
   );

   mdu_mul u_mul (
      .rclk(rclk), .arst_n(arst_n),
      .start(mul_start), .is_signed(mul_signed), .a(rs1), .b(rs2),
      .product(product), .valid(mul_valid)
   );

   // High product word goes straight into Y
   mdu_yreg u_yreg (
      .rclk(rclk), .arst_n(arst_n),
      .sw_wen(y_wen), .sw_thr(y_wthr), .sw_wdata(y_wdata),
      .mul_wen(y_mul_wen), .mul_thr(op_thr),
      .mul_wdata(product[2*`MDU_XLEN-1:`MDU_XLEN]),
      .rd_thr(y_rthr), .rd_data(y_rdata),
      .op_thr(op_thr), .op_data(y_op)
   );

endmodule

//--- hw/mdu_mul.sv
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_mul
   import mdu_pkg::*;
(
   input  logic       rclk,
   input  logic       arst_n,
   input  logic       start,       // Operands valid this cycle
   input  logic       is_signed,   // SMUL
   input  mdu_word_t  a,
   input  mdu_word_t  b,
   output mdu_dword_t product,
   output logic       valid
);

   logic [`MDU_MUL_LAT-1:0]       vld_q;       // One bit per stage
   logic signed [`MDU_XLEN:0]     a_q;         // Extended by one sign bit
   logic signed [`MDU_XLEN:0]     b_q;
   logic signed [2*`MDU_XLEN+1:0] prod_full;

   ////////////////////////////////////////
   // Stage valids
   ////////////////////////////////////////
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[`MDU_MUL_LAT-2:0], start};
      end
   end

   // Stage one, extend once so one signed multiplier covers both ops
   always_ff @(posedge rclk) begin
      if (start) begin
         a_q <= {is_signed && a[`MDU_XLEN-1], a};
         b_q <= {is_signed && b[`MDU_XLEN-1], b};
      end
   end

   assign prod_full = a_q * b_q;

   // Stage two, held until the next operand pair arrives
   always_ff @(posedge rclk) begin
      if (vld_q[0]) begin
         product <= prod_full[2*`MDU_XLEN-1:0];
      end
   end

   assign valid = vld_q[`MDU_MUL_LAT-1];

endmodule

//--- hw/mdu_div_dp.sv
`timescale 1ns/1ns

module mdu_div_dp
   import mdu_pkg::*;
(
   input  logic       rclk,
   input  logic       arst_n,
   input  mdu_word_t  rs1,       // Lower dividend word
   input  mdu_word_t  rs2,       // Divisor
   input  mdu_word_t  y_op,      // Upper dividend word
   input  mdu_dword_t product,   // From multiplier, low word used here
   input  logic       done,
   output mdu_word_t  result,
   output logic       flag_n,
   output logic       flag_z,
   output logic       flag_v,
   mdu_div_ctl_if.dp  ctl
);

   localparam int W = $bits(mdu_word_t);

   mdu_dword_t dvd_in;
   mdu_dword_t dvd_mag;     // Dividend magnitude
   mdu_word_t  dvs_mag;     // Divisor magnitude
   logic       neg_in;      // Quotient sign at load
   mdu_dword_t quo_q;       // Dividend shifting out, quotient shifting in
   mdu_word_t  rem_q;       // Partial remainder
   mdu_word_t  dvs_q;
   logic       neg_q;
   logic [W:0]   shifted;   // Remainder after the left shift
   logic [W+1:0] diff;      // Shared adder output, top bit is the borrow
   logic       no_borrow;
   logic       ovf;
   mdu_word_t  sat_val;
   mdu_word_t  fix_val;
   mdu_word_t  div_res_q;   // Saturated signed-fixed quotient
   logic       div_v_q;
   mdu_word_t  res_live;
   mdu_word_t  res_hold;
   logic       n_hold;
   logic       z_hold;
   logic       v_hold;

   ////////////////////////////////////////
   // Operand conditioning
   ////////////////////////////////////////
   assign dvd_in  = {y_op, rs1};
   assign dvd_mag = (ctl.signed_op && dvd_in[2*W-1]) ? -dvd_in : dvd_in;
   assign dvs_mag = (ctl.signed_op && rs2[W-1]) ? -rs2 : rs2;
   assign neg_in  = ctl.signed_op && (dvd_in[2*W-1] ^ rs2[W-1]);

   assign ctl.dvs_zero = ~|dvs_q;

   ////////////////////////////////////////
   // Restoring iteration
   ////////////////////////////////////////
   assign shifted   = {rem_q, quo_q[2*W-1]};
   assign diff      = {1'b0, shifted} - {2'b00, dvs_q};   // Trial subtract
   assign no_borrow = ~diff[W+1];

   always_ff @(posedge rclk) begin
      if (ctl.ld_inputs) begin
         quo_q <= dvd_mag;
         rem_q <= '0;
         dvs_q <= dvs_mag;
         neg_q <= neg_in;
      end else if (ctl.step) begin
         // Keep difference only when divisor fits
         rem_q <= no_borrow ? diff[W-1:0] : shifted[W-1:0];
         quo_q <= {quo_q[2*W-2:0], no_borrow};
      end
   end

   ////////////////////////////////////////
   // Sign fix and 32-bit saturation
   ////////////////////////////////////////
   always_comb begin
      if (!ctl.signed_op) begin
         ovf     = |quo_q[2*W-1:W];
         sat_val = '1;                            // Unsigned overflow
      end else if (!neg_q) begin
         ovf     = |quo_q[2*W-1:W-1];
         sat_val = {1'b0, {(W-1){1'b1}}};         // Largest positive
      end else begin
         // Magnitude 2^31 still fits as a negative result
         ovf     = (|quo_q[2*W-1:W]) || (quo_q[W-1] && (|quo_q[W-2:0]));
         sat_val = {1'b1, {(W-1){1'b0}}};         // Most negative
      end
      if (ovf) begin
         fix_val = sat_val;
      end else begin
         fix_val = neg_q ? -quo_q[W-1:0] : quo_q[W-1:0];
      end
   end

   ////////////////////////////////////////
   // Result select and hold
   ////////////////////////////////////////
   assign res_live = ctl.sel_div ? div_res_q : product[W-1:0];

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         div_res_q <= '0;
         div_v_q   <= 1'b0;
         res_hold  <= '0;
         n_hold    <= 1'b0;
         z_hold    <= 1'b0;
         v_hold    <= 1'b0;
      end else begin
         if (ctl.ld_inputs) begin
            div_res_q <= '0;             // Zero divisor leaves this in place
            div_v_q   <= 1'b0;
         end else if (ctl.fix) begin
            div_res_q <= fix_val;
            div_v_q   <= ovf;
         end
         if (done) begin
            res_hold <= res_live;
            n_hold   <= res_live[W-1];
            z_hold   <= ~|res_live;
            v_hold   <= ctl.sel_div && div_v_q;
         end
      end
   end

   // Sources are stable during done, the held copy covers the time after
   assign result = done ? res_live : res_hold;
   assign flag_n = done ? res_live[W-1] : n_hold;
   assign flag_z = done ? ~|res_live : z_hold;
   assign flag_v = done ? (ctl.sel_div && div_v_q) : v_hold;   // Never set by a multiply

endmodule

//--- hw/mdu_seq.sv
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_seq
   import mdu_pkg::*;
(
   input  logic       rclk,
   input  logic       arst_n,
   input  logic       start,
   input  mdu_op_e    op,
   input  mdu_thr_t   thr,
   input  logic       mul_valid,
   output logic       busy,
   output logic       done,
   output logic       div_zero,
   output logic       mul_start,
   output logic       mul_signed,
   output logic       y_mul_wen,
   output mdu_thr_t   op_thr,
   mdu_div_ctl_if.ctl ctl
);

   localparam int CNT_W = $clog2(`MDU_DIV_ITERS);

   typedef enum logic [2:0] {
      ST_IDLE,   // Waiting for start
      ST_MUL,    // Multiplier pipeline running
      ST_DLD,    // Operands loaded, divisor checked
      ST_DIT,    // Restoring iterations
      ST_DFIX,   // Sign fix and saturation
      ST_FIN     // Result registered on the way out
   } state_e;

   state_e           state_q;
   state_e           state_nx;
   mdu_op_e          op_q;
   mdu_op_e          cur_op;
   mdu_thr_t         thr_q;
   logic [CNT_W-1:0] cnt_q;      // Iteration count
   logic             accept;
   logic             is_div;
   logic             last_iter;
   logic             dz_pend_q;  // Zero divisor seen, not yet reported

   ////////////////////////////////////////
   // Issue and steering
   ////////////////////////////////////////
   assign busy   = (state_q != ST_IDLE) || done;   // Covers the done cycle too
   assign accept = start && !busy;

   // Live inputs in the start cycle, held copies afterwards
   assign cur_op = busy ? op_q : op;
   assign op_thr = busy ? thr_q : thr;
   assign is_div = cur_op inside {UDIV, SDIV};

   assign mul_start  = accept && !is_div;
   assign mul_signed = (op == SMUL);

   assign ctl.ld_inputs = accept && is_div;          // Load on the start edge
   assign ctl.step      = (state_q == ST_DIT);
   assign ctl.fix       = (state_q == ST_DFIX);
   assign ctl.signed_op = (cur_op == SDIV);
   assign ctl.sel_div   = is_div;

   assign y_mul_wen = (state_q == ST_FIN) && !is_div;   // Same edge as result
   assign last_iter = (cnt_q == CNT_W'(`MDU_DIV_ITERS - 1));

   ////////////////////////////////////////
   // FSM
   ////////////////////////////////////////
   always_comb begin
      state_nx = state_q;
      case (state_q)
         ST_IDLE: begin
            if (accept) begin
               state_nx = is_div ? ST_DLD : ST_MUL;
            end
         end
         ST_MUL: begin
            if (mul_valid) begin
               state_nx = ST_FIN;
            end
         end
         ST_DLD:  state_nx = ctl.dvs_zero ? ST_FIN : ST_DIT;   // Early exit on /0
         ST_DIT: begin
            if (last_iter) begin
               state_nx = ST_DFIX;
            end
         end
         ST_DFIX: state_nx = ST_FIN;
         ST_FIN:  state_nx = ST_IDLE;
         default: state_nx = ST_IDLE;
      endcase
   end

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         state_q   <= ST_IDLE;
         op_q      <= UMUL;
         thr_q     <= '0;
         cnt_q     <= '0;
         dz_pend_q <= 1'b0;
         done      <= 1'b0;
         div_zero  <= 1'b0;
      end else begin
         state_q <= state_nx;
         done    <= (state_q == ST_FIN);   // Single-cycle pulse
         if (accept) begin
            op_q      <= op;
            thr_q     <= thr;
            dz_pend_q <= 1'b0;
         end
         if (state_q == ST_DLD) begin
            dz_pend_q <= ctl.dvs_zero;
         end
         // Counter only advances while iterating
         cnt_q <= (state_q == ST_DIT) ? cnt_q + 1'b1 : '0;
         if (state_q == ST_FIN) begin
            div_zero <= dz_pend_q;   // Held until the next done
         end
      end
   end

endmodule

//--- hw/mdu_yreg.sv
`timescale 1ns/1ns
`include "mdu_consts.svh"

module mdu_yreg
   import mdu_pkg::*;
(
   input  logic      rclk,
   input  logic      arst_n,
   input  logic      sw_wen,      // Software write strobe
   input  mdu_thr_t  sw_thr,
   input  mdu_word_t sw_wdata,
   input  logic      mul_wen,     // High product from a finished multiply
   input  mdu_thr_t  mul_thr,
   input  mdu_word_t mul_wdata,
   input  mdu_thr_t  rd_thr,      // Software read port
   output mdu_word_t rd_data,
   input  mdu_thr_t  op_thr,      // Operation read port
   output mdu_word_t op_data
);

   mdu_word_t               y_q [`MDU_NUM_THR];
   logic [`MDU_NUM_THR-1:0] sw_hit;    // Per-thread decode of sw port
   logic [`MDU_NUM_THR-1:0] mul_hit;   // Per-thread decode of mul port

   // Thread decode for both write ports
   always_comb begin
      for (int t = 0; t < `MDU_NUM_THR; t++) begin
         sw_hit[t]  = sw_wen && (sw_thr == mdu_thr_t'(t));
         mul_hit[t] = mul_wen && (mul_thr == mdu_thr_t'(t));
      end
   end

   ////////////////////////////////////////
   // Y storage
   ////////////////////////////////////////
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         for (int t = 0; t < `MDU_NUM_THR; t++) begin
            y_q[t] <= '0;
         end
      end else begin
         for (int t = 0; t < `MDU_NUM_THR; t++) begin
            if (sw_hit[t]) begin
               y_q[t] <= sw_wdata;         // Software has priority
            end else if (mul_hit[t]) begin
               y_q[t] <= mul_wdata;
            end
         end
      end
   end

   // Two independent combinational reads
   assign rd_data = y_q[rd_thr];
   assign op_data = y_q[op_thr];   // Upper dividend word

endmodule

//--- hw/mdu_div_ctl_if.sv
`timescale 1ns/1ns

// Control and status between divide sequencer and divide datapath
interface mdu_div_ctl_if;

   logic ld_inputs;   // Load operand magnitudes, single cycle
   logic step;        // One restoring iteration per cycle while high
   logic fix;         // Sign fix and saturation, single cycle
   logic signed_op;   // SDIV, stable for the whole divide
   logic sel_div;     // Output takes the divider result
   logic dvs_zero;    // Loaded divisor is zero

   // Sequencer side
   modport ctl (
      output ld_inputs,
      output step,
      output fix,
      output signed_op,
      output sel_div,
      input  dvs_zero
   );

   // Datapath side
   modport dp (
      input  ld_inputs,
      input  step,
      input  fix,
      input  signed_op,
      input  sel_div,
      output dvs_zero
   );

endinterface

//--- hw/mdu_pkg.sv
package mdu_pkg;

   ////////////////////////////////////////
   // Operation encoding
   ////////////////////////////////////////

   // Bit 1 marks a divide, bit 0 a signed op
   typedef enum logic [1:0] {
      UMUL = 2'b00,
      SMUL = 2'b01,
      UDIV = 2'b10,
      SDIV = 2'b11
   } mdu_op_e;

   ////////////////////////////////////////
   // Data types
   ////////////////////////////////////////

   typedef logic [31:0] mdu_word_t;    // Register word, rs1/rs2/result/Y

   typedef logic [63:0] mdu_dword_t;   // Full product or {Y, rs1} dividend

   typedef logic [1:0]  mdu_thr_t;     // Thread id

endpackage

//--- hw/mdu_consts.svh
`ifndef MDU_CONSTS_SVH
`define MDU_CONSTS_SVH

////////////////////////////////////////
// Unit sizing
////////////////////////////////////////

// Register word width
`define MDU_XLEN 32

// Hardware threads, one Y register each
`define MDU_NUM_THR 4

// Restoring steps, one per dividend bit
`define MDU_DIV_ITERS 64

// Operand stage plus product stage
`define MDU_MUL_LAT 2

`endif
